//--- idu_pkg.sv
package idu_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int ALU_OP_W = 5;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [6:0] F7_NORM = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // funct3 named after the arithmetic group, reused by branch and load/store
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [ALU_OP_W-1:0] ALU_NOP   = 5'd0;
    localparam logic [ALU_OP_W-1:0] ALU_ADD   = 5'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SUB   = 5'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SLT   = 5'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 5'd4;
    localparam logic [ALU_OP_W-1:0] ALU_XOR   = 5'd5;
    localparam logic [ALU_OP_W-1:0] ALU_OR    = 5'd6;
    localparam logic [ALU_OP_W-1:0] ALU_AND   = 5'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLL   = 5'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SRL   = 5'd9;
    localparam logic [ALU_OP_W-1:0] ALU_SRA   = 5'd10;
    localparam logic [ALU_OP_W-1:0] ALU_BEQ   = 5'd11;
    localparam logic [ALU_OP_W-1:0] ALU_BNE   = 5'd12;
    localparam logic [ALU_OP_W-1:0] ALU_BLT   = 5'd13;
    localparam logic [ALU_OP_W-1:0] ALU_BGE   = 5'd14;
    localparam logic [ALU_OP_W-1:0] ALU_BLTU  = 5'd15;
    localparam logic [ALU_OP_W-1:0] ALU_BGEU  = 5'd16;
    localparam logic [ALU_OP_W-1:0] ALU_LB    = 5'd17;
    localparam logic [ALU_OP_W-1:0] ALU_LH    = 5'd18;
    localparam logic [ALU_OP_W-1:0] ALU_LW    = 5'd19;
    localparam logic [ALU_OP_W-1:0] ALU_LBU   = 5'd20;
    localparam logic [ALU_OP_W-1:0] ALU_LHU   = 5'd21;
    localparam logic [ALU_OP_W-1:0] ALU_SB    = 5'd22;
    localparam logic [ALU_OP_W-1:0] ALU_SH    = 5'd23;
    localparam logic [ALU_OP_W-1:0] ALU_SW    = 5'd24;
    localparam logic [ALU_OP_W-1:0] ALU_LUI   = 5'd25;
    localparam logic [ALU_OP_W-1:0] ALU_AUIPC = 5'd26;
    localparam logic [ALU_OP_W-1:0] ALU_JAL   = 5'd27;
    localparam logic [ALU_OP_W-1:0] ALU_JALR  = 5'd28;

    typedef struct packed {
        logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] rd; logic [6:0] opcode;
    } fmt_r_t;

    typedef struct packed {
        logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
        logic [4:0] rd; logic [6:0] opcode;
    } fmt_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [4:0] imm_4_0; logic [6:0] opcode;
    } fmt_s_t;

    typedef struct packed {
        logic imm_12; logic [5:0] imm_10_5; logic [4:0] rs2; logic [4:0] rs1;
        logic [2:0] funct3; logic [3:0] imm_4_1; logic imm_11; logic [6:0] opcode;
    } fmt_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
    } fmt_u_t;

    typedef struct packed {
        logic imm_20; logic [9:0] imm_10_1; logic imm_11; logic [7:0] imm_19_12;
        logic [4:0] rd; logic [6:0] opcode;
    } fmt_j_t;

    typedef union packed {
        fmt_r_t r;
        fmt_i_t i;
        fmt_s_t s;
        fmt_b_t b;
        fmt_u_t u;
        fmt_j_t j;
    } instr_u;

    // one register write in flight
    typedef struct packed {
        logic              vld;
        logic [REG_AW-1:0] addr;
        logic [XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        wb_t  wb;
        logic ld;
    } bypass_t;

    typedef struct packed {
        logic [XLEN-1:0]     src1;
        logic [XLEN-1:0]     src2;
        logic [XLEN-1:0]     pc;
        logic [XLEN-1:0]     br_st_imm;
        logic [REG_AW-1:0]   wb_addr;
        logic                wb_vld;
        logic [ALU_OP_W-1:0] alu_op;
    } issue_t;

endpackage

//--- idu_op_decode.sv
`timescale 1ns/1ns

module idu_op_decode (
    input  idu_pkg::instr_u              ins_i,
    output logic [idu_pkg::ALU_OP_W-1:0] alu_op_o,
    output logic                         wb_vld_o,
    output logic                         use_rs1_o,
    output logic                         use_rs2_o,
    output logic                         src2_imm_o
);
    import idu_pkg::*;

    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       fmt_r;
    logic       fmt_i;
    logic       fmt_s;
    logic       fmt_b;
    logic       fmt_u;
    logic       fmt_j;

    assign opc = ins_i.r.opcode;
    assign f3  = ins_i.r.funct3;
    assign f7  = ins_i.r.funct7;

    assign fmt_r = (opc == OPC_OP);
    assign fmt_i = (opc == OPC_OP_IMM) | (opc == OPC_LOAD) | (opc == OPC_JALR);
    assign fmt_s = (opc == OPC_STORE);
    assign fmt_b = (opc == OPC_BRANCH);
    assign fmt_u = (opc == OPC_LUI) | (opc == OPC_AUIPC);
    assign fmt_j = (opc == OPC_JAL);

    assign wb_vld_o   = fmt_r | fmt_i | fmt_u | fmt_j;
    assign use_rs1_o  = fmt_r | fmt_i | fmt_s | fmt_b;
    assign use_rs2_o  = fmt_r | fmt_s | fmt_b;
    assign src2_imm_o = fmt_i | fmt_u | fmt_j;

    always_comb begin
        logic plain;
        // immediate forms ignore funct7 except on shifts
        plain = (opc == OPC_OP_IMM) | (f7 == F7_NORM);
        alu_op_o = ALU_NOP;
        case (opc)
            OPC_OP, OPC_OP_IMM: begin
                case (f3)
                    F3_ADD: begin
                        if (plain) begin
                            alu_op_o = ALU_ADD;
                        end else if (fmt_r && f7 == F7_ALT) begin
                            alu_op_o = ALU_SUB;
                        end
                    end
                    F3_SLT:  alu_op_o = plain ? ALU_SLT : ALU_NOP;
                    F3_SLTU: alu_op_o = plain ? ALU_SLTU : ALU_NOP;
                    F3_XOR:  alu_op_o = plain ? ALU_XOR : ALU_NOP;
                    F3_OR:   alu_op_o = plain ? ALU_OR : ALU_NOP;
                    F3_AND:  alu_op_o = plain ? ALU_AND : ALU_NOP;
                    F3_SLL:  alu_op_o = (f7 == F7_NORM) ? ALU_SLL : ALU_NOP;
                    default: begin
                        if (f7 == F7_NORM) begin
                            alu_op_o = ALU_SRL;
                        end else if (f7 == F7_ALT) begin
                            alu_op_o = ALU_SRA;
                        end
                    end
                endcase
            end
            OPC_BRANCH: begin
                case (f3)
                    F3_ADD:  alu_op_o = ALU_BEQ;
                    F3_SLL:  alu_op_o = ALU_BNE;
                    F3_XOR:  alu_op_o = ALU_BLT;
                    F3_SR:   alu_op_o = ALU_BGE;
                    F3_OR:   alu_op_o = ALU_BLTU;
                    F3_AND:  alu_op_o = ALU_BGEU;
                    default: alu_op_o = ALU_NOP;
                endcase
            end
            OPC_LOAD: begin
                case (f3)
                    F3_ADD:  alu_op_o = ALU_LB;
                    F3_SLL:  alu_op_o = ALU_LH;
                    F3_SLT:  alu_op_o = ALU_LW;
                    F3_XOR:  alu_op_o = ALU_LBU;
                    F3_SR:   alu_op_o = ALU_LHU;
                    default: alu_op_o = ALU_NOP;
                endcase
            end
            OPC_STORE: begin
                case (f3)
                    F3_ADD:  alu_op_o = ALU_SB;
                    F3_SLL:  alu_op_o = ALU_SH;
                    F3_SLT:  alu_op_o = ALU_SW;
                    default: alu_op_o = ALU_NOP;
                endcase
            end
            OPC_LUI:   alu_op_o = ALU_LUI;
            OPC_AUIPC: alu_op_o = ALU_AUIPC;
            OPC_JAL:   alu_op_o = ALU_JAL;
            OPC_JALR:  alu_op_o = ALU_JALR;
            default:   alu_op_o = ALU_NOP;
        endcase
    end

endmodule

//--- idu_imm_gen.sv
`timescale 1ns/1ns

module idu_imm_gen (
    input  idu_pkg::instr_u          ins_i,
    output logic [idu_pkg::XLEN-1:0] imm_o,
    output logic [idu_pkg::XLEN-1:0] br_st_imm_o
);
    import idu_pkg::*;

    logic [6:0]      opc;
    logic            fmt_i;
    logic            fmt_s;
    logic            fmt_b;
    logic            fmt_u;
    logic            fmt_j;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opc   = ins_i.r.opcode;
    assign fmt_i = (opc == OPC_OP_IMM) | (opc == OPC_LOAD) | (opc == OPC_JALR);
    assign fmt_s = (opc == OPC_STORE);
    assign fmt_b = (opc == OPC_BRANCH);
    assign fmt_u = (opc == OPC_LUI) | (opc == OPC_AUIPC);
    assign fmt_j = (opc == OPC_JAL);

    assign imm_i = {{(XLEN-12){ins_i.i.imm[11]}}, ins_i.i.imm};
    assign imm_s = {{(XLEN-12){ins_i.s.imm_11_5[6]}}, ins_i.s.imm_11_5, ins_i.s.imm_4_0};
    // branch and jump offsets are halfword aligned
    assign imm_b = {{(XLEN-13){ins_i.b.imm_12}}, ins_i.b.imm_12, ins_i.b.imm_11,
                    ins_i.b.imm_10_5, ins_i.b.imm_4_1, 1'b0};
    assign imm_u = {ins_i.u.imm_31_12, 12'h000};
    assign imm_j = {{(XLEN-21){ins_i.j.imm_20}}, ins_i.j.imm_20, ins_i.j.imm_19_12,
                    ins_i.j.imm_11, ins_i.j.imm_10_1, 1'b0};

    // formats are mutually exclusive, so an and-or select is enough
    assign imm_o = ({XLEN{fmt_i}} & imm_i)
                 | ({XLEN{fmt_s}} & imm_s)
                 | ({XLEN{fmt_b}} & imm_b)
                 | ({XLEN{fmt_u}} & imm_u)
                 | ({XLEN{fmt_j}} & imm_j);

    assign br_st_imm_o = ({XLEN{fmt_b}} & imm_b) | ({XLEN{fmt_s}} & imm_s);

endmodule

//--- idu_fwd.sv
`timescale 1ns/1ns

module idu_fwd (
    input  logic [idu_pkg::REG_AW-1:0] rs1_i,
    input  logic [idu_pkg::REG_AW-1:0] rs2_i,
    input  logic                       use_rs1_i,
    input  logic                       use_rs2_i,
    input  idu_pkg::bypass_t           alu_byp_i,
    input  idu_pkg::bypass_t           lsu_byp_i,
    input  idu_pkg::wb_t               rf_wb_i,
    input  logic [idu_pkg::XLEN-1:0]   rf_src1_data_i,
    input  logic [idu_pkg::XLEN-1:0]   rf_src2_data_i,
    output logic [idu_pkg::XLEN-1:0]   src1_o,
    output logic [idu_pkg::XLEN-1:0]   src2_o,
    output logic                       ld_hazard_o
);
    import idu_pkg::*;

    logic [XLEN:0] sel1;
    logic [XLEN:0] sel2;

    // returns {load pending, operand}
    function automatic logic [XLEN:0] fwd_sel(
        input logic [REG_AW-1:0] rs,
        input logic              use_rs,
        input bypass_t           alu,
        input bypass_t           lsu,
        input wb_t               rf_wb,
        input logic [XLEN-1:0]   rf_data
    );
        logic live;
        logic alu_hit;
        logic lsu_hit;
        logic rf_hit;
        live    = use_rs & (rs != '0);
        alu_hit = live & alu.wb.vld & (alu.wb.addr == rs);
        lsu_hit = live & lsu.wb.vld & (lsu.wb.addr == rs);
        rf_hit  = live & rf_wb.vld & (rf_wb.addr == rs);
        // youngest producer wins
        if (alu_hit) begin
            fwd_sel = {alu.ld, alu.wb.data};
        end else if (lsu_hit) begin
            fwd_sel = {lsu.ld, lsu.wb.data};
        end else if (rf_hit) begin
            fwd_sel = {1'b0, rf_wb.data};
        end else begin
            fwd_sel = {1'b0, rf_data};
        end
    endfunction

    assign sel1 = fwd_sel(rs1_i, use_rs1_i, alu_byp_i, lsu_byp_i, rf_wb_i, rf_src1_data_i);
    assign sel2 = fwd_sel(rs2_i, use_rs2_i, alu_byp_i, lsu_byp_i, rf_wb_i, rf_src2_data_i);

    assign src1_o      = sel1[XLEN-1:0];
    assign src2_o      = sel2[XLEN-1:0];
    assign ld_hazard_o = sel1[XLEN] | sel2[XLEN];

endmodule

//--- idu_issue_reg.sv
`timescale 1ns/1ns

module idu_issue_reg (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            ifu_vld_i,
    input  logic            flush_i,
    input  logic            ld_hazard_i,
    input  logic            alu_rdy_i,
    input  idu_pkg::issue_t issue_i,
    output logic            ifu_rdy_o,
    output logic            alu_vld_o,
    output idu_pkg::issue_t issue_o
);
    import idu_pkg::*;

    logic   accept;
    logic   wb_vld_q;
    issue_t issue_q;

    // room when empty or draining this cycle
    assign ifu_rdy_o = (~alu_vld_o | alu_rdy_i) & ~ld_hazard_i;
    assign accept    = ifu_vld_i & ifu_rdy_o & ~flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            alu_vld_o <= 1'b0;
            wb_vld_q  <= 1'b0;
        end else begin
            alu_vld_o <= accept | (alu_vld_o & ~alu_rdy_i);
            if (accept) begin
                wb_vld_q <= issue_i.wb_vld;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            issue_q <= issue_i;
        end
    end

    // writeback flag comes from the reset copy
    always_comb begin
        issue_o        = issue_q;
        issue_o.wb_vld = wb_vld_q;
    end

endmodule

//--- idu_top.sv
`timescale 1ns/1ns

module idu_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       ifu_vld_i,
    input  logic [idu_pkg::XLEN-1:0]   ifu_ins_i,
    input  logic [idu_pkg::XLEN-1:0]   ifu_pc_i,
    output logic                       ifu_rdy_o,
    input  logic                       alu_rdy_i,
    input  logic                       alu_flush_i,
    input  idu_pkg::bypass_t           alu_byp_i,
    input  idu_pkg::bypass_t           lsu_byp_i,
    input  idu_pkg::wb_t               rf_wb_i,
    input  logic [idu_pkg::XLEN-1:0]   rf_src1_data_i,
    input  logic [idu_pkg::XLEN-1:0]   rf_src2_data_i,
    output logic [idu_pkg::REG_AW-1:0] rf_src1_addr_o,
    output logic [idu_pkg::REG_AW-1:0] rf_src2_addr_o,
    output logic                       alu_vld_o,
    output idu_pkg::issue_t            alu_issue_o
);
    import idu_pkg::*;

    instr_u              ins;
    logic [ALU_OP_W-1:0] alu_op;
    logic                wb_vld;
    logic                use_rs1;
    logic                use_rs2;
    logic                src2_imm;
    logic [XLEN-1:0]     imm;
    logic [XLEN-1:0]     br_st_imm;
    logic [XLEN-1:0]     src1;
    logic [XLEN-1:0]     src2_reg;
    logic                ld_hazard;
    issue_t              issue_d;

    assign ins            = ifu_ins_i;
    assign rf_src1_addr_o = ins.r.rs1;
    assign rf_src2_addr_o = ins.r.rs2;

    idu_op_decode u_op_decode (
        .ins_i      (ins),
        .alu_op_o   (alu_op),
        .wb_vld_o   (wb_vld),
        .use_rs1_o  (use_rs1),
        .use_rs2_o  (use_rs2),
        .src2_imm_o (src2_imm)
    );

    idu_imm_gen u_imm_gen (
        .ins_i       (ins),
        .imm_o       (imm),
        .br_st_imm_o (br_st_imm)
    );

    idu_fwd u_fwd (
        .rs1_i          (ins.r.rs1),
        .rs2_i          (ins.r.rs2),
        .use_rs1_i      (use_rs1),
        .use_rs2_i      (use_rs2),
        .alu_byp_i      (alu_byp_i),
        .lsu_byp_i      (lsu_byp_i),
        .rf_wb_i        (rf_wb_i),
        .rf_src1_data_i (rf_src1_data_i),
        .rf_src2_data_i (rf_src2_data_i),
        .src1_o         (src1),
        .src2_o         (src2_reg),
        .ld_hazard_o    (ld_hazard)
    );

    // pre-register issue word, src2 taken from the immediate for I/U/J
    assign issue_d = '{
        src1:      src1,
        src2:      src2_imm ? imm : src2_reg,
        pc:        ifu_pc_i,
        br_st_imm: br_st_imm,
        wb_addr:   ins.r.rd,
        wb_vld:    wb_vld,
        alu_op:    alu_op
    };

    idu_issue_reg u_issue_reg (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ifu_vld_i   (ifu_vld_i),
        .flush_i     (alu_flush_i),
        .ld_hazard_i (ld_hazard),
        .alu_rdy_i   (alu_rdy_i),
        .issue_i     (issue_d),
        .ifu_rdy_o   (ifu_rdy_o),
        .alu_vld_o   (alu_vld_o),
        .issue_o     (alu_issue_o)
    );

endmodule

//--- idu_checker.sv
`timescale 1ns/1ns

module idu_checker (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            ifu_rdy_i,
    input  logic            ld_hazard_i,
    input  logic            alu_vld_i,
    input  logic            alu_rdy_i,
    input  idu_pkg::issue_t issue_i
);
    import idu_pkg::*;

    int err_cnt = 0;

    a_vld_reset: assert property (@(posedge clk_i) !rst_n_i |=> !alu_vld_i) else begin
        err_cnt++;
        $error("alu_vld_o high in the cycle after reset");
    end

    // back-pressure holds the word in place
    a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alu_vld_i && !alu_rdy_i |=> alu_vld_i && $stable(issue_i)) else begin
        err_cnt++;
        $error("issue word changed while the ALU was not ready");
    end

    // a hazard holds off fetch and leaves the issue register empty
    a_hazard_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ld_hazard_i && (!alu_vld_i || alu_rdy_i) |=> !alu_vld_i && !$past(ifu_rdy_i))
        else begin
        err_cnt++;
        $error("fetch accepted or an issue word loaded during a load-use hazard");
    end

endmodule

bind idu_issue_reg idu_checker u_checker (
    .clk_i       (clk),
    .rst_n_i     (rst_n_i),
    .ifu_rdy_i   (ifu_rdy_o),
    .ld_hazard_i (ld_hazard_i),
    .alu_vld_i   (alu_vld_o),
    .alu_rdy_i   (alu_rdy_i),
    .issue_i     (issue_o)
);

//--- idu_tb.sv
`timescale 1ns/1ns

module idu_tb;
    import idu_pkg::*;

    // where an operand is expected to come from
    localparam logic [2:0] S_RF  = 3'd0;
    localparam logic [2:0] S_ALU = 3'd1;
    localparam logic [2:0] S_LSU = 3'd2;
    localparam logic [2:0] S_WB  = 3'd3;
    localparam logic [2:0] S_IMM = 3'd4;

    localparam logic [31:0] ALU_DATA = 32'ha1a1_0001;
    localparam logic [31:0] LSU_DATA = 32'hb2b2_0002;
    localparam logic [31:0] WB_DATA  = 32'hc3c3_0003;

    // bypass fields are {vld, ld, addr}
    // ctl is {flush, hazard, hold[1:0]}
    typedef struct packed {
        logic [31:0] ins;
        logic [6:0]  alu;
        logic [6:0]  lsu;
        logic [6:0]  wb;
        logic        flush;
        logic        hazard;
        logic [1:0]  hold;
        logic [2:0]  src1;
        logic [2:0]  src2;
        logic [31:0] imm;
        logic [31:0] bsi;
        logic [4:0]  op;
        logic        wbv;
        logic [4:0]  wba;
    } test_t;

    logic        clk;
    logic        rst_n;
    logic        ifu_vld;
    logic [31:0] ifu_ins;
    logic [31:0] ifu_pc;
    logic        ifu_rdy;
    logic        alu_rdy;
    logic        alu_flush;
    bypass_t     alu_byp;
    bypass_t     lsu_byp;
    wb_t         rf_wb;
    logic [31:0] rf1_data;
    logic [31:0] rf2_data;
    logic [4:0]  rf1_addr;
    logic [4:0]  rf2_addr;
    logic        alu_vld;
    issue_t      alu_issue;

    test_t  tests[$];
    string  names[$];
    integer seed;
    int     errors;
    int     passed;
    int     cycles;
    int     limit = 1000;
    logic   test_bad;

    idu_top uut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .ifu_vld_i      (ifu_vld),
        .ifu_ins_i      (ifu_ins),
        .ifu_pc_i       (ifu_pc),
        .ifu_rdy_o      (ifu_rdy),
        .alu_rdy_i      (alu_rdy),
        .alu_flush_i    (alu_flush),
        .alu_byp_i      (alu_byp),
        .lsu_byp_i      (lsu_byp),
        .rf_wb_i        (rf_wb),
        .rf_src1_data_i (rf1_data),
        .rf_src2_data_i (rf2_data),
        .rf_src1_addr_o (rf1_addr),
        .rf_src2_addr_o (rf2_addr),
        .alu_vld_o      (alu_vld),
        .alu_issue_o    (alu_issue)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: no handshake from the DUT within %0d cycles", limit);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic bypass_t make_byp(input logic [6:0] cfg, input logic [31:0] data);
        bypass_t b;
        b.wb.vld  = cfg[6];
        b.ld      = cfg[5];
        b.wb.addr = cfg[4:0];
        b.wb.data = data;
        return b;
    endfunction

    function automatic logic [31:0] src_value(
        input logic [2:0]  sel,
        input logic [31:0] rf,
        input logic [31:0] imm
    );
        case (sel)
            S_ALU:   return ALU_DATA;
            S_LSU:   return LSU_DATA;
            S_WB:    return WB_DATA;
            S_IMM:   return imm;
            default: return rf;
        endcase
    endfunction

    task automatic check(
        input string       name,
        input string       what,
        input logic [31:0] exp,
        input logic [31:0] act
    );
        if (exp !== act) begin
            $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic add_test(input string name, input test_t t);
        names.push_back(name);
        tests.push_back(t);
    endtask

    task automatic run_test(input int k);
        test_t       t;
        bypass_t     wb_tmp;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] pc;
        issue_t      held;
        t = tests[k];
        test_bad = 1'b0;
        r1 = $random(seed);
        r2 = $random(seed);
        pc = $random(seed);
        wb_tmp = make_byp(t.wb, WB_DATA);
        @(posedge clk);
        ifu_vld   <= 1'b1;
        ifu_ins   <= t.ins;
        ifu_pc    <= pc;
        alu_flush <= t.flush;
        alu_rdy   <= 1'b0;
        rf1_data  <= r1;
        rf2_data  <= r2;
        alu_byp   <= make_byp(t.alu, ALU_DATA);
        lsu_byp   <= make_byp(t.lsu, LSU_DATA);
        rf_wb     <= wb_tmp.wb;
        if (t.flush) begin
            repeat (3) begin
                @(negedge clk);
                check(names[k], "alu_vld", 32'd0, alu_vld);
            end
            @(posedge clk);
            ifu_vld   <= 1'b0;
            alu_flush <= 1'b0;
            @(negedge clk);
            check(names[k], "alu_vld", 32'd0, alu_vld);
        end else begin
            if (t.hazard) begin
                repeat (3) begin
                    @(negedge clk);
                    check(names[k], "ifu_rdy", 32'd0, ifu_rdy);
                    check(names[k], "alu_vld", 32'd0, alu_vld);
                end
                // load data arrives and the ld bits drop
                @(posedge clk);
                alu_byp <= make_byp({t.alu[6], 1'b0, t.alu[4:0]}, ALU_DATA);
                lsu_byp <= make_byp({t.lsu[6], 1'b0, t.lsu[4:0]}, LSU_DATA);
            end
            @(negedge clk);
            check(names[k], "ifu_rdy", 32'd1, ifu_rdy);
            check(names[k], "rs1 addr", t.ins[19:15], rf1_addr);
            check(names[k], "rs2 addr", t.ins[24:20], rf2_addr);
            while (!ifu_rdy) begin
                @(negedge clk);
            end
            @(posedge clk);
            ifu_vld <= 1'b0;
            @(negedge clk);
            check(names[k], "alu_vld", 32'd1, alu_vld);
            check(names[k], "src1", src_value(t.src1, r1, t.imm), alu_issue.src1);
            check(names[k], "src2", src_value(t.src2, r2, t.imm), alu_issue.src2);
            check(names[k], "pc", pc, alu_issue.pc);
            check(names[k], "br_st_imm", t.bsi, alu_issue.br_st_imm);
            check(names[k], "alu_op", t.op, alu_issue.alu_op);
            check(names[k], "wb_vld", t.wbv, alu_issue.wb_vld);
            check(names[k], "wb_addr", t.wba, alu_issue.wb_addr);
            held = alu_issue;
            repeat (t.hold) begin
                @(negedge clk);
                check(names[k], "issue stable", 32'd1, alu_issue === held);
                check(names[k], "ifu_rdy", 32'd0, ifu_rdy);
            end
            @(posedge clk);
            alu_rdy <= 1'b1;
            @(posedge clk);
            alu_rdy <= 1'b0;
            @(negedge clk);
            check(names[k], "alu_vld", 32'd0, alu_vld);
        end
        if (test_bad) begin
            $display("%-14s failed", names[k]);
        end else begin
            passed++;
            $display("%-14s passed", names[k]);
        end
    endtask

    initial begin
        int fails;
        int asrt;
        seed      = 32'he3169a03;
        rst_n     = 1'b0;
        ifu_vld   = 1'b0;
        ifu_ins   = '0;
        ifu_pc    = '0;
        alu_rdy   = 1'b0;
        alu_flush = 1'b0;
        alu_byp   = '0;
        lsu_byp   = '0;
        rf_wb     = '0;
        rf1_data  = '0;
        rf2_data  = '0;
        errors    = 0;
        passed    = 0;
        cycles    = 0;

        // ins, alu, lsu, wb, ctl, src1, src2, imm, br_st_imm, op, wb_vld, wb_addr
        add_test("add", {32'h006283B3, 7'h00, 7'h00, 7'h00, 4'b0001, S_RF, S_RF,
            32'h0, 32'h0, ALU_ADD, 1'b1, 5'd7});
        add_test("sub", {32'h406283B3, 7'h00, 7'h00, 7'h00, 4'b0000, S_RF, S_RF,
            32'h0, 32'h0, ALU_SUB, 1'b1, 5'd7});
        add_test("sra", {32'h4062D3B3, 7'h00, 7'h00, 7'h00, 4'b0000, S_RF, S_RF,
            32'h0, 32'h0, ALU_SRA, 1'b1, 5'd7});
        add_test("xori", {32'hFFF2C393, 7'h00, 7'h00, 7'h00, 4'b0000, S_RF, S_IMM,
            32'hFFFFFFFF, 32'h0, ALU_XOR, 1'b1, 5'd7});
        add_test("srai", {32'h4032D393, 7'h00, 7'h00, 7'h00, 4'b0001, S_RF, S_IMM,
            32'h00000403, 32'h0, ALU_SRA, 1'b1, 5'd7});
        add_test("lw", {32'hFFC2A383, 7'h00, 7'h00, 7'h00, 4'b0000, S_RF, S_IMM,
            32'hFFFFFFFC, 32'h0, ALU_LW, 1'b1, 5'd7});
        add_test("sw", {32'h0062AA23, 7'h00, 7'h00, 7'h00, 4'b0000, S_RF, S_RF,
            32'h0, 32'h00000014, ALU_SW, 1'b0, 5'd20});
        add_test("bne", {32'hFE629CE3, 7'h00, 7'h00, 7'h00, 4'b0001, S_RF, S_RF,
            32'h0, 32'hFFFFFFF8, ALU_BNE, 1'b0, 5'd25});
        // pending load on the unused rs1 field must not stall
        add_test("lui", {32'hABCDE3B7, 7'h7B, 7'h00, 7'h00, 4'b0000, S_RF, S_IMM,
            32'hABCDE000, 32'h0, ALU_LUI, 1'b1, 5'd7});
        add_test("auipc", {32'h00001397, 7'h00, 7'h00, 7'h00, 4'b0000, S_RF, S_IMM,
            32'h00001000, 32'h0, ALU_AUIPC, 1'b1, 5'd7});
        add_test("jal", {32'h010000EF, 7'h00, 7'h00, 7'h00, 4'b0000, S_RF, S_IMM,
            32'h00000010, 32'h0, ALU_JAL, 1'b1, 5'd1});
        add_test("jalr", {32'h008280E7, 7'h00, 7'h00, 7'h00, 4'b0000, S_RF, S_IMM,
            32'h00000008, 32'h0, ALU_JALR, 1'b1, 5'd1});
        add_test("fwd_alu_lsu", {32'h006283B3, 7'h45, 7'h45, 7'h46, 4'b0000, S_ALU, S_WB,
            32'h0, 32'h0, ALU_ADD, 1'b1, 5'd7});
        add_test("fwd_lsu_wb", {32'h006283B3, 7'h49, 7'h46, 7'h46, 4'b0000, S_RF, S_LSU,
            32'h0, 32'h0, ALU_ADD, 1'b1, 5'd7});
        add_test("fwd_alu_wb", {32'h006283B3, 7'h46, 7'h45, 7'h46, 4'b0000, S_LSU, S_ALU,
            32'h0, 32'h0, ALU_ADD, 1'b1, 5'd7});
        add_test("fwd_x0", {32'h000003B3, 7'h40, 7'h40, 7'h40, 4'b0000, S_RF, S_RF,
            32'h0, 32'h0, ALU_ADD, 1'b1, 5'd7});
        // pending load on the unused rs2 field must not stall
        add_test("fwd_i_rs2", {32'h00628393, 7'h66, 7'h45, 7'h00, 4'b0000, S_LSU, S_IMM,
            32'h00000006, 32'h0, ALU_ADD, 1'b1, 5'd7});
        add_test("load_use_alu", {32'h006283B3, 7'h66, 7'h00, 7'h00, 4'b0100, S_RF, S_ALU,
            32'h0, 32'h0, ALU_ADD, 1'b1, 5'd7});
        add_test("load_use_lsu", {32'h006283B3, 7'h00, 7'h65, 7'h00, 4'b0110, S_LSU, S_RF,
            32'h0, 32'h0, ALU_ADD, 1'b1, 5'd7});
        add_test("alu_hold", {32'h006283B3, 7'h00, 7'h00, 7'h00, 4'b0011, S_RF, S_RF,
            32'h0, 32'h0, ALU_ADD, 1'b1, 5'd7});
        add_test("flush", {32'h006283B3, 7'h00, 7'h00, 7'h00, 4'b1000, S_RF, S_RF,
            32'h0, 32'h0, ALU_ADD, 1'b1, 5'd7});
        limit = tests.size() * 12 + 8;

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        test_bad = 1'b0;
        @(negedge clk);
        check("reset", "alu_vld", 32'd0, alu_vld);
        check("reset", "wb_vld", 32'd0, alu_issue.wb_vld);
        check("reset", "ifu_rdy", 32'd1, ifu_rdy);

        for (int k = 0; k < tests.size(); k++) begin
            run_test(k);
        end
        @(posedge clk);

        fails = tests.size() - passed;
        asrt  = uut.u_issue_reg.u_checker.err_cnt;
        $display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d assertion errors",
            tests.size(), passed, fails, errors, asrt);
        if (errors == 0 && fails == 0 && asrt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- idu_top.f
idu_pkg.sv
idu_op_decode.sv
idu_imm_gen.sv
idu_fwd.sv
idu_issue_reg.sv
idu_top.sv
idu_checker.sv
idu_tb.sv

//--- Bender.yml
package:
  name: idu

sources:
  - idu_pkg.sv
  - idu_op_decode.sv
  - idu_imm_gen.sv
  - idu_fwd.sv
  - idu_issue_reg.sv
  - idu_top.sv
  - target: test
    files:
      - idu_checker.sv
      - idu_tb.sv
